//--- project.f
source/cpu_types_pkg.sv
source/sq_pkg.sv
source/sq_control.sv
source/sq_entry_file.sv
source/sq_store_formatter.sv
source/store_queue.sv
testbench/tb_store_queue.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the store queue testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

# Modules without their own timeunit get the testbench's
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_store_queue -f project.f -o sim_store_queue
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

output=$(./obj_dir/sim_store_queue)
run_status=$?
echo "$output"

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- source/cpu_types_pkg.sv
package cpu_types_pkg;

    // Basic machine words
    typedef logic [31:0] addr_t;        // Byte address
    typedef logic [31:0] data_t;        // Register value
    typedef logic [63:0] mem_block_t;   // One data memory bus beat

    // Access size, encoded like funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_size_t;

    // R-type layout, also used to pick funct3 out of any instruction
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // S-type layout, immediate split around funct3
    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        logic [4:0] rs2;        // Store value source
        logic [4:0] rs1;        // Base register
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        logic [6:0] opcode;
    } inst_s_t;

    // Same 32 bits, two decodes
    typedef union packed {
        inst_r_t r;
        inst_s_t s;
    } inst_t;

endpackage

//--- source/sq_control.sv
module sq_control (
    input  logic                    clock,
    input  logic                    reset,
    input  sq_pkg::dispatch_count_t dispatch_count,  // Stores entering this cycle
    input  logic                    retire_store,    // ROB wants the head store sent
    input  logic                    mem_busy,        // Memory cannot take a request
    input  logic                    flush,           // Branch mispredict recovery
    input  sq_pkg::sq_index_t       flush_tail,      // Tail saved at the branch
    output logic                    retire_fire,
    output sq_pkg::sq_index_t       head,
    output sq_pkg::sq_credit_t      credits
);
    import sq_pkg::*;

    sq_index_t tail;            // One past the youngest dispatched store
    sq_count_t occupancy;       // Dispatched and not yet retired

    sq_index_t next_head;
    sq_index_t next_tail;
    sq_index_t rollback;        // Entries squashed by a flush
    sq_count_t next_occupancy;
    sq_count_t free_entries;    // Slots available to dispatch this cycle

    // Memory back-pressure or an empty queue hold the ROB off
    assign retire_fire = retire_store && !mem_busy && (occupancy != '0);

    always_comb begin
        // Distance from restored tail to current tail, wraps mod depth
        rollback = flush ? sq_index_t'(tail - flush_tail) : '0;

        // Dispatch stacks on top of the restored tail
        next_tail = (flush ? flush_tail : tail) + sq_index_t'(dispatch_count);
        next_head = head + sq_index_t'(retire_fire);

        next_occupancy = occupancy
                       - sq_count_t'(rollback)
                       + sq_count_t'(dispatch_count)
                       - sq_count_t'(retire_fire);
    end

    // A slot freed by this cycle's retirement is offered right away
    always_comb begin
        free_entries = sq_count_t'(SQ_DEPTH) - occupancy + sq_count_t'(retire_fire);

        if (free_entries > sq_count_t'(DISPATCH_WIDTH)) begin
            credits.open_entries = dispatch_count_t'(DISPATCH_WIDTH);  // Capped by dispatch width
        end else begin
            credits.open_entries = dispatch_count_t'(free_entries);
        end

        credits.head = head;
        credits.tail = tail;    // Index handed to the next dispatched store
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= next_head;
            tail      <= next_tail;
            occupancy <= next_occupancy;
        end
    end

endmodule

//--- source/sq_entry_file.sv
module sq_entry_file (
    input  logic                                          clock,
    input  logic                                          reset,
    input  sq_pkg::sq_issue_t [sq_pkg::ISSUE_LANES-1:0]   issue,
    input  sq_pkg::sq_index_t                             head,
    input  logic                                          retire_fire,  // Head leaves this cycle
    output sq_pkg::sq_entry_t                             head_entry
);
    import cpu_types_pkg::*;
    import sq_pkg::*;

    sq_entry_t  entries    [SQ_DEPTH];
    sq_entry_t  lane_entry [ISSUE_LANES];   // Entry each lane would write
    logic [11:0] s_imm     [ISSUE_LANES];   // Reassembled S-type immediate

    // Address generation, one adder per lane
    always_comb begin
        for (int l = 0; l < ISSUE_LANES; l++) begin
            s_imm[l] = {issue[l].inst.s.imm_hi, issue[l].inst.s.imm_lo};

            lane_entry[l].address     = issue[l].base + {{20{s_imm[l][11]}}, s_imm[l]};
            lane_entry[l].store_value = issue[l].store_value;
            // funct3 low bits give the width, same field in every view
            lane_entry[l].size        = mem_size_t'(issue[l].inst.r.funct3[1:0]);
        end
    end

    // Head read, a same-cycle issue to the head slot wins
    always_comb begin
        head_entry = entries[head];
        for (int l = 0; l < ISSUE_LANES; l++) begin
            if (issue[l].valid && (issue[l].sq_index == head)) begin
                head_entry = lane_entry[l];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int l = 0; l < ISSUE_LANES; l++) begin
                if (issue[l].valid) begin
                    entries[issue[l].sq_index] <= lane_entry[l];  // Higher lane wins a tie
                end
            end

            // Retired slot is emptied, even if it was written just now
            if (retire_fire) begin
                entries[head] <= '0;
            end
        end
    end

endmodule

//--- source/sq_pkg.sv
package sq_pkg;

    // Queue geometry
    localparam int SQ_DEPTH       = 8;
    localparam int SQ_INDEX_BITS  = 3;
    localparam int DISPATCH_WIDTH = 2;  // Stores dispatched per cycle, at most
    localparam int ISSUE_LANES    = 2;  // Issue write ports

    typedef logic [SQ_INDEX_BITS-1:0] sq_index_t;
    typedef logic [SQ_INDEX_BITS:0]   sq_count_t;        // 0 to SQ_DEPTH
    typedef logic [1:0]               dispatch_count_t;  // 0 to DISPATCH_WIDTH

    // One store arriving from an issue lane
    typedef struct packed {
        logic                  valid;
        sq_index_t             sq_index;     // Slot reserved at dispatch
        cpu_types_pkg::inst_t  inst;
        cpu_types_pkg::data_t  base;         // rs1 value
        cpu_types_pkg::data_t  store_value;  // rs2 value
    } sq_issue_t;

    // Stored state of one queue slot
    typedef struct packed {
        cpu_types_pkg::addr_t      address;
        cpu_types_pkg::data_t      store_value;
        cpu_types_pkg::mem_size_t  size;
    } sq_entry_t;

    // Store request toward data memory
    typedef struct packed {
        logic                       valid;
        cpu_types_pkg::addr_t       address;
        cpu_types_pkg::mem_block_t  block;
        logic [7:0]                 byte_enable;
        cpu_types_pkg::mem_size_t   size;
    } mem_request_t;

    // Credits and pointers returned to dispatch
    typedef struct packed {
        dispatch_count_t  open_entries;
        sq_index_t        head;
        sq_index_t        tail;
    } sq_credit_t;

endpackage

//--- source/sq_store_formatter.sv
module sq_store_formatter (
    input  sq_pkg::sq_entry_t    head_entry,
    input  logic                 retire_fire,
    output sq_pkg::mem_request_t mem_request
);
    import cpu_types_pkg::*;

    logic [2:0] offset;         // Byte position inside the 64-bit block
    data_t      lane_word;      // Store value replicated by size
    logic [7:0] size_mask;      // Enables before shifting to the offset

    assign offset = head_entry.address[2:0];

    always_comb begin
        case (head_entry.size)
            MEM_BYTE: begin
                lane_word = {4{head_entry.store_value[7:0]}};
                size_mask = 8'b0000_0001;
            end
            MEM_HALF: begin
                lane_word = {2{head_entry.store_value[15:0]}};
                size_mask = 8'b0000_0011;
            end
            default: begin      // Word, and the unused encoding
                lane_word = head_entry.store_value;
                size_mask = 8'b0000_1111;
            end
        endcase
    end

    always_comb begin
        mem_request = '0;       // Idle bus when nothing retires
        if (retire_fire) begin
            mem_request.valid       = 1'b1;
            mem_request.address     = head_entry.address;
            mem_request.block       = mem_block_t'(lane_word) << {offset, 3'b000};
            mem_request.byte_enable = size_mask << offset;
            mem_request.size        = head_entry.size;
        end
    end

endmodule

//--- source/store_queue.sv
module store_queue (
    input  logic                                          clock,
    input  logic                                          reset,

    // Dispatch, never more than credits.open_entries
    input  sq_pkg::dispatch_count_t                       dispatch_count,

    // Issue lanes fill slots reserved at dispatch
    input  sq_pkg::sq_issue_t [sq_pkg::ISSUE_LANES-1:0]   issue,

    // ROB retirement and memory back-pressure
    input  logic                                          retire_store,
    input  logic                                          mem_busy,

    // Branch recovery
    input  logic                                          flush,
    input  sq_pkg::sq_index_t                             flush_tail,

    output sq_pkg::sq_credit_t                            credits,
    output sq_pkg::mem_request_t                          mem_request
);
    import sq_pkg::*;

    sq_index_t head;            // Oldest store
    logic      retire_fire;     // Head goes to memory this cycle
    sq_entry_t head_entry;      // Head slot, with issue bypass

    // Pointers, occupancy and credits
    sq_control u_control (
        .clock          (clock),
        .reset          (reset),
        .dispatch_count (dispatch_count),
        .retire_store   (retire_store),
        .mem_busy       (mem_busy),
        .flush          (flush),
        .flush_tail     (flush_tail),
        .retire_fire    (retire_fire),
        .head           (head),
        .credits        (credits)
    );

    // Slot storage and address generation
    sq_entry_file u_entry_file (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .head        (head),
        .retire_fire (retire_fire),
        .head_entry  (head_entry)
    );

    // Byte lane placement for the memory bus
    sq_store_formatter u_store_formatter (
        .head_entry  (head_entry),
        .retire_fire (retire_fire),
        .mem_request (mem_request)
    );

endmodule

//--- testbench/tb_store_queue.sv
module tb_store_queue;
    timeunit 1ns;
    timeprecision 100ps;

    import cpu_types_pkg::*;
    import sq_pkg::*;

    // One cycle of stimulus with the outputs expected in that cycle
    typedef struct packed {
        dispatch_count_t dispatch;
        sq_issue_t       lane0;
        sq_issue_t       lane1;
        logic            retire;
        logic            busy;
        logic            flush;
        sq_index_t       flush_tail;
        sq_credit_t      exp_credits;
        mem_request_t    exp_request;
    } row_t;

    logic                             clock;
    logic                             reset;
    dispatch_count_t                  dispatch_count;
    sq_issue_t [ISSUE_LANES-1:0]      issue;
    logic                             retire_store;
    logic                             mem_busy;
    logic                             flush;
    sq_index_t                        flush_tail;
    sq_credit_t                       credits;
    mem_request_t                     mem_request;

    row_t         rows[$];
    sq_issue_t    stores[11];       // Issue packets used by the rows
    mem_request_t sent[11];         // Request each packet should produce
    sq_issue_t    no_issue;
    mem_request_t no_request;
    int           credit_errors;
    int           request_errors;
    int           cycle_count;
    int           cycle_limit;

    store_queue dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch_count (dispatch_count),
        .issue          (issue),
        .retire_store   (retire_store),
        .mem_busy       (mem_busy),
        .flush          (flush),
        .flush_tail     (flush_tail),
        .credits        (credits),
        .mem_request    (mem_request)
    );

    always #10 clock = ~clock;      // 20 ns period

    // Store packet in S-type encoding, funct3 low bits are the size
    function automatic sq_issue_t store_packet(int index, mem_size_t size, logic [11:0] imm,
                                               data_t base, data_t value);
        sq_issue_t p;
        p                 = '0;
        p.valid           = 1'b1;
        p.sq_index        = sq_index_t'(index);
        p.inst.s.imm_hi   = imm[11:5];
        p.inst.s.rs2      = 5'd6;
        p.inst.s.rs1      = 5'd5;
        p.inst.s.funct3   = {1'b0, size};
        p.inst.s.imm_lo   = imm[4:0];
        p.inst.s.opcode   = 7'b0100011;   // STORE
        p.base            = base;
        p.store_value     = value;
        return p;
    endfunction

    function automatic mem_request_t request(addr_t address, mem_block_t block,
                                             logic [7:0] byte_enable, mem_size_t size);
        mem_request_t r;
        r.valid       = 1'b1;
        r.address     = address;
        r.block       = block;
        r.byte_enable = byte_enable;
        r.size        = size;
        return r;
    endfunction

    task automatic add_row(int dispatch, sq_issue_t lane0, sq_issue_t lane1, int retire,
                           int busy, int do_flush, int restore, int open, int head,
                           int tail, mem_request_t exp_request);
        row_t r;
        r.dispatch    = dispatch_count_t'(dispatch);
        r.lane0       = lane0;
        r.lane1       = lane1;
        r.retire      = (retire != 0);
        r.busy        = (busy != 0);
        r.flush       = (do_flush != 0);
        r.flush_tail  = sq_index_t'(restore);
        r.exp_credits = '{dispatch_count_t'(open), sq_index_t'(head), sq_index_t'(tail)};
        r.exp_request = exp_request;
        rows.push_back(r);
    endtask

    task automatic build_table();
        no_issue   = '0;
        no_request = '0;
        stores[0] = store_packet(0, MEM_WORD, 12'h010, 32'h1000_0000, 32'hdead_beef);
        sent[0]   = request(32'h1000_0010, 64'h0000_0000_dead_beef, 8'h0f, MEM_WORD);
        stores[1] = store_packet(1, MEM_BYTE, 12'hffb, 32'h2000_0100, 32'h1234_56a5);
        sent[1]   = request(32'h2000_00fb, 64'h00a5_a5a5_a500_0000, 8'h08, MEM_BYTE);
        stores[2] = store_packet(2, MEM_HALF, 12'h006, 32'h0000_4000, 32'hcafe_1234);
        sent[2]   = request(32'h0000_4006, 64'h1234_0000_0000_0000, 8'hc0, MEM_HALF);
        stores[3] = store_packet(3, MEM_WORD, 12'h7fc, 32'h0000_8000, 32'h8765_4321);
        sent[3]   = request(32'h0000_87fc, 64'h8765_4321_0000_0000, 8'hf0, MEM_WORD);
        stores[4] = store_packet(4, MEM_BYTE, 12'h800, 32'h3000_0000, 32'h0000_005a);
        sent[4]   = request(32'h2fff_f800, 64'h0000_0000_5a5a_5a5a, 8'h01, MEM_BYTE);
        stores[5] = store_packet(5, MEM_HALF, 12'h000, 32'h0000_0200, 32'h0000_beef);
        sent[5]   = request(32'h0000_0200, 64'h0000_0000_beef_beef, 8'h03, MEM_HALF);
        stores[6] = store_packet(6, MEM_WORD, 12'hff8, 32'h4000_0000, 32'h1111_2222);
        sent[6]   = request(32'h3fff_fff8, 64'h0000_0000_1111_2222, 8'h0f, MEM_WORD);
        stores[7] = store_packet(7, MEM_WORD, 12'h000, 32'h5000_0000, 32'h0bad_0bad);
        sent[7]   = no_request;         // Overwritten before it retires
        stores[8] = store_packet(7, MEM_BYTE, 12'h003, 32'h0000_0010, 32'h0000_00c3);
        sent[8]   = request(32'h0000_0013, 64'h00c3_c3c3_c300_0000, 8'h08, MEM_BYTE);
        stores[9] = store_packet(0, MEM_WORD, 12'h004, 32'h0000_1000, 32'h0102_0304);
        sent[9]   = request(32'h0000_1004, 64'h0102_0304_0000_0000, 8'hf0, MEM_WORD);
        stores[10] = store_packet(1, MEM_HALF, 12'hffe, 32'h0000_2000, 32'h0000_7788);
        sent[10]   = request(32'h0000_1ffe, 64'h7788_0000_0000_0000, 8'hc0, MEM_HALF);

        // dispatch, lane0, lane1, retire, busy, flush, flush_tail, open, head, tail, request
        add_row(0, no_issue, no_issue, 0, 0, 0, 0, 2, 0, 0, no_request);    // Reset state
        add_row(2, no_issue, no_issue, 0, 0, 0, 0, 2, 0, 0, no_request);
        add_row(2, stores[1], stores[0], 0, 0, 0, 0, 2, 0, 2, no_request);  // Out of order
        add_row(2, stores[3], no_issue, 0, 0, 0, 0, 2, 0, 4, no_request);
        add_row(2, stores[2], stores[5], 0, 0, 0, 0, 2, 0, 6, no_request);
        add_row(0, stores[4], stores[6], 0, 0, 0, 0, 0, 0, 0, no_request);  // Full
        add_row(0, no_issue, stores[7], 1, 0, 0, 0, 1, 0, 0, sent[0]);      // Full and retiring
        add_row(0, no_issue, no_issue, 1, 1, 0, 0, 1, 1, 0, no_request);    // Memory busy
        add_row(0, no_issue, no_issue, 1, 1, 0, 0, 1, 1, 0, no_request);
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 1, 0, sent[1]);       // Same entry sent
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 2, 0, sent[2]);
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 3, 0, sent[3]);
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 4, 0, sent[4]);
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 5, 0, sent[5]);
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 6, 0, sent[6]);
        add_row(0, no_issue, stores[8], 1, 0, 0, 0, 2, 7, 0, sent[8]);      // Head bypass
        add_row(0, no_issue, no_issue, 1, 0, 0, 0, 2, 0, 0, no_request);    // Empty queue
        add_row(2, no_issue, no_issue, 0, 0, 0, 0, 2, 0, 0, no_request);
        add_row(2, stores[9], stores[10], 0, 0, 0, 0, 2, 0, 2, no_request);
        add_row(2, no_issue, no_issue, 1, 0, 0, 0, 2, 0, 4, sent[9]);
        add_row(2, no_issue, no_issue, 1, 0, 0, 0, 2, 1, 6, sent[10]);
        add_row(1, no_issue, no_issue, 0, 0, 0, 0, 2, 2, 0, no_request);    // Tail wraps
        add_row(0, no_issue, no_issue, 0, 0, 1, 5, 1, 2, 1, no_request);    // Flush above head
        add_row(1, no_issue, no_issue, 0, 0, 1, 3, 2, 2, 5, no_request);    // Flush plus dispatch
        add_row(2, no_issue, no_issue, 0, 0, 0, 0, 2, 2, 4, no_request);
        add_row(2, no_issue, no_issue, 0, 0, 0, 0, 2, 2, 6, no_request);
        add_row(2, no_issue, no_issue, 0, 0, 0, 0, 2, 2, 0, no_request);    // Exactly 2 left
        add_row(0, no_issue, no_issue, 0, 0, 0, 0, 0, 2, 2, no_request);    // Full again
    endtask

    task automatic check_credits(int row, sq_credit_t actual, sq_credit_t expected);
        if (actual !== expected) begin
            credit_errors++;
            $display("** Error at %0t: row %0d open/head/tail %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, row, actual.open_entries, actual.head, actual.tail,
                     expected.open_entries, expected.head, expected.tail);
        end
    endtask

    task automatic check_request(int row, mem_request_t actual, mem_request_t expected);
        if (actual !== expected) begin
            request_errors++;
            $display("** Error at %0t: row %0d memory request mismatch", $time, row);
            $display("    got      valid %0b addr %h block %h be %h size %0d", actual.valid,
                     actual.address, actual.block, actual.byte_enable, actual.size);
            $display("    expected valid %0b addr %h block %h be %h size %0d", expected.valid,
                     expected.address, expected.block, expected.byte_enable, expected.size);
        end
    endtask

    // Run limit grows with the table
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the test table did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_count = '0;
        issue          = '0;
        retire_store   = 1'b0;
        mem_busy       = 1'b0;
        flush          = 1'b0;
        flush_tail     = '0;
        credit_errors  = 0;
        request_errors = 0;
        cycle_count    = 0;
        build_table();
        cycle_limit    = rows.size() + 20;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        foreach (rows[i]) begin
            @(posedge clock);
            dispatch_count <= rows[i].dispatch;
            issue[0]       <= rows[i].lane0;
            issue[1]       <= rows[i].lane1;
            retire_store   <= rows[i].retire;
            mem_busy       <= rows[i].busy;
            flush          <= rows[i].flush;
            flush_tail     <= rows[i].flush_tail;
            @(negedge clock);                   // Combinational outputs settled
            check_credits(i, credits, rows[i].exp_credits);
            check_request(i, mem_request, rows[i].exp_request);
        end

        $display("Credit errors: %0d, request errors: %0d", credit_errors, request_errors);
        if (credit_errors == 0 && request_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
